// File: bench/ps2_kbd_tb.sv
`timescale 1ns/1ps
module ps2_kbd_tb;
    import ps2_kbd_pkg::*;

    localparam int HALF_BIT  = 1500;                    // clk cycles in half of a 60 us bit.
    localparam int BUS_LIMIT = 200;

    logic       clk = 1'b0;
    logic       rst_n;
    logic       ps2_clk;
    logic       ps2_data;
    axil_req_t  req;
    axil_rsp_t  rsp;
    seg_bus_t   segs;

    logic [7:0] model_q [$];
    logic [7:0] model_count;
    logic [7:0] model_last;
    logic       model_held;
    logic       model_brk;
    logic       model_ovf;
    logic       model_ferr;
    logic       model_en;
    int         checks;
    int         errors;
    int         tests;
    int         failed_tests;
    int         test_start_errors;

    ps2_kbd_top dut_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .ps2_clk  (ps2_clk),
        .ps2_data (ps2_data),
        .req      (req),
        .rsp      (rsp),
        .segs     (segs)
    );

    always #10 clk = ~clk;

    task automatic flag_error(input string msg);
        errors++;
        $display("** Error (%0t ns): %s", $time, msg);
    endtask

    task automatic check_val(input string what, input logic [41:0] got, input logic [41:0] exp);
        checks++;
        value_ok: assert (got === exp) else
            flag_error($sformatf("%s: got %0h, expected %0h", what, got, exp));
    endtask

    task automatic bus_timeout(input string what);
        $display("timeout while waiting for %s, the bus did not answer", what);
        $display("TB FAILED");
        $finish;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // bus protocol checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    rvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        rsp.rvalid && !req.rready |=> rsp.rvalid)
        else flag_error("rvalid dropped before rready");
    bvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        rsp.bvalid && !req.bready |=> rsp.bvalid)
        else flag_error("bvalid dropped before bready");
    rdata_stable: assert property (@(posedge clk) disable iff (!rst_n)
        rsp.rvalid && !req.rready |=> $stable(rsp.rdata))
        else flag_error("rdata changed while rvalid was waiting");
    rvalid_requested: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(rsp.rvalid) |-> $past(req.arvalid && rsp.arready))
        else flag_error("rvalid rose without a read address handshake");
    bvalid_requested: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(rsp.bvalid) |-> $past(req.awvalid && req.wvalid && rsp.awready))
        else flag_error("bvalid rose without a write handshake");
    ready_pair: assert property (@(posedge clk) disable iff (!rst_n)
        rsp.awready == rsp.wready)
        else flag_error("awready and wready did not rise together");

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic reset_model();
        model_q.delete();
        model_count = 8'd0;
        model_held  = 1'b0;
        model_brk   = 1'b0;
        model_ovf   = 1'b0;
        model_ferr  = 1'b0;
    endtask

    task automatic apply_to_model(input logic [7:0] code);
        if (code == 8'hF0) begin
            model_brk = 1'b1;
        end else if (model_brk) begin
            model_brk  = 1'b0;                          // released key, nothing stored.
            model_held = 1'b0;
        end else if (!(model_held && code == model_last)) begin
            model_last  = code;
            model_held  = 1'b1;
            model_count = model_count + 8'd1;
            if (model_q.size() < 8) begin
                model_q.push_back(code);
            end else begin
                model_ovf = 1'b1;
            end
        end
    endtask

    function automatic logic [31:0] expected_status();
        logic [3:0] lvl;
        lvl = 4'(model_q.size());
        return {24'd0, lvl, model_held, model_ferr, model_ovf, model_q.size() != 0};
    endfunction

    // lit segments in abcdefg order. The pins are active low.
    function automatic logic [6:0] digit_pattern(input logic [3:0] v);
        logic [6:0] lit;
        case (v)
            4'h0: lit = 7'b1111110;
            4'h1: lit = 7'b0110000;
            4'h2: lit = 7'b1101101;
            4'h3: lit = 7'b1111001;
            4'h4: lit = 7'b0110011;
            4'h5: lit = 7'b1011011;
            4'h6: lit = 7'b1011111;
            4'h7: lit = 7'b1110000;
            4'h8: lit = 7'b1111111;
            4'h9: lit = 7'b1111011;
            4'hA: lit = 7'b1110111;
            4'hB: lit = 7'b0011111;
            4'hC: lit = 7'b1001110;
            4'hD: lit = 7'b0111101;
            4'hE: lit = 7'b1001111;
            default: lit = 7'b1000111;
        endcase
        return ~lit;
    endfunction

    function automatic seg_bus_t expected_segs();
        seg_bus_t s;
        int       lvl;
        int       cnt;
        s   = '1;
        lvl = model_q.size();
        cnt = model_count % 100;
        if (model_en) begin
            if (lvl != 0) begin
                s.d0 = digit_pattern(model_q[0][3:0]);
                s.d1 = digit_pattern(model_q[0][7:4]);
            end
            s.d2 = digit_pattern(4'(cnt % 10));
            s.d3 = digit_pattern(4'(cnt / 10));
            s.d4 = digit_pattern(4'(lvl % 10));
            s.d5 = digit_pattern(4'(lvl / 10));
        end
        return s;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // keyboard and bus drivers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic send_frame(input logic [7:0] code, input logic bad_parity);
        logic [10:0] bits;
        bits = {1'b1, ~(^code) ^ bad_parity, code, 1'b0};  // stop, odd parity, data, start.
        for (int i = 0; i < 11; i++) begin
            ps2_data <= bits[i];
            repeat (HALF_BIT / 2) @(posedge clk);
            ps2_clk <= 1'b0;
            repeat (HALF_BIT) @(posedge clk);
            ps2_clk <= 1'b1;
            repeat (HALF_BIT / 2) @(posedge clk);
        end
        ps2_data <= 1'b1;
        repeat (HALF_BIT) @(posedge clk);
        if (bad_parity) begin
            model_ferr = 1'b1;
        end else begin
            apply_to_model(code);
        end
    endtask

    task automatic axi_read(input logic [3:0] addr, input int delay, output logic [31:0] data);
        int n;
        req.araddr  <= addr;
        req.arvalid <= 1'b1;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!rsp.arready && n < BUS_LIMIT);
        if (!rsp.arready) begin
            bus_timeout("arready");
        end
        req.arvalid <= 1'b0;
        repeat (delay) @(posedge clk);                  // holds rvalid against a slow master.
        req.rready <= 1'b1;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!rsp.rvalid && n < BUS_LIMIT);
        if (!rsp.rvalid) begin
            bus_timeout("rvalid");
        end
        data = rsp.rdata;
        check_val("read response", rsp.rresp, RESP_OKAY);
        req.rready <= 1'b0;
    endtask

    task automatic axi_write(input logic [3:0] addr, input logic [31:0] data, input int delay,
                             output logic [1:0] resp);
        int n;
        req.awaddr  <= addr;
        req.awvalid <= 1'b1;
        req.wdata   <= data;
        req.wstrb   <= 4'hF;
        req.wvalid  <= 1'b1;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!rsp.awready && n < BUS_LIMIT);
        if (!rsp.awready) begin
            bus_timeout("awready");
        end
        req.awvalid <= 1'b0;
        req.wvalid  <= 1'b0;
        repeat (delay) @(posedge clk);
        req.bready <= 1'b1;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!rsp.bvalid && n < BUS_LIMIT);
        if (!rsp.bvalid) begin
            bus_timeout("bvalid");
        end
        resp = rsp.bresp;
        req.bready <= 1'b0;
    endtask

    task automatic expect_read(input logic [3:0] addr, input int delay, input logic [31:0] exp,
                               input string what);
        logic [31:0] data;
        axi_read(addr, delay, data);
        check_val(what, data, exp);
    endtask

    task automatic expect_pop(input int delay);
        logic [31:0] exp;
        exp = 32'd0;                                    // an empty FIFO reads as zero.
        if (model_q.size() != 0) begin
            exp = {24'd0, model_q.pop_front()};
        end
        expect_read(ADDR_DATA, delay, exp, "data pop");
    endtask

    task automatic write_ctrl(input logic [31:0] value, input int delay);
        logic [1:0] resp;
        axi_write(ADDR_CTRL, value, delay, resp);
        check_val("ctrl write response", resp, RESP_OKAY);
        if (value[0]) begin
            reset_model();
        end
        model_en = value[1];
    endtask

    task automatic end_test(input string name);
        tests++;
        if (errors == test_start_errors) begin
            $display("test %0d %s: ok", tests, name);
        end else begin
            failed_tests++;
            $display("test %0d %s: %0d errors", tests, name, errors - test_start_errors);
        end
        test_start_errors = errors;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        logic [1:0] resp;
        logic [7:0] codes [$];
        logic [7:0] c;
        logic       dup;
        void'($urandom(5));
        rst_n    <= 1'b0;
        ps2_clk  <= 1'b1;
        ps2_data <= 1'b1;
        req      <= '0;
        reset_model();
        model_last        = 8'd0;
        model_en          = 1'b1;
        checks            = 0;
        errors            = 0;
        tests             = 0;
        failed_tests      = 0;
        test_start_errors = 0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        expect_read(ADDR_CTRL, 0, {30'd0, model_en, 1'b0}, "ctrl after reset");
        send_frame(8'h1C, 1'b0);
        send_frame(8'hF0, 1'b0);
        send_frame(8'h1C, 1'b0);
        expect_read(ADDR_STATUS, 0, expected_status(), "status after release");
        expect_pop(0);
        expect_read(ADDR_STATUS, 0, expected_status(), "status after pop");
        expect_read(ADDR_COUNT, 0, {24'd0, model_count}, "press count");
        end_test("press, release and read");

        write_ctrl(32'h3, 0);
        for (int i = 0; i < 3; i++) begin
            send_frame(8'h2B, 1'b0);
        end
        send_frame(8'hF0, 1'b0);
        send_frame(8'h2B, 1'b0);
        send_frame(8'h2B, 1'b0);
        expect_read(ADDR_STATUS, 1, expected_status(), "status with two entries");
        expect_read(ADDR_COUNT, 0, {24'd0, model_count}, "press count");
        expect_pop(0);
        expect_pop(2);
        expect_pop(0);
        end_test("typematic repeat");

        write_ctrl(32'h3, 0);
        while (codes.size() < 10) begin
            c   = 8'($urandom_range(8'hEF, 8'h01));     // never the break prefix.
            dup = 1'b0;
            foreach (codes[k]) begin
                if (codes[k] == c) begin
                    dup = 1'b1;
                end
            end
            if (!dup) begin
                codes.push_back(c);
            end
        end
        foreach (codes[k]) begin
            send_frame(codes[k], 1'b0);
        end
        check_val("segments at overflow", segs, expected_segs());
        expect_read(ADDR_STATUS, 0, expected_status(), "status after overflow");
        for (int i = 0; i < 9; i++) begin
            expect_pop(i % 3);
        end
        expect_read(ADDR_COUNT, 0, {24'd0, model_count}, "press count");
        end_test("overflow");

        send_frame(8'h33, 1'b1);
        expect_read(ADDR_STATUS, 0, expected_status(), "status after parity error");
        end_test("parity error");

        send_frame(8'h45, 1'b0);
        write_ctrl(32'h3, 2);
        expect_read(ADDR_STATUS, 0, expected_status(), "status after clear");
        expect_read(ADDR_COUNT, 0, {24'd0, model_count}, "press count after clear");
        check_val("segments after clear", segs, expected_segs());
        axi_write(ADDR_COUNT, 32'h55, 0, resp);
        check_val("count write response", resp, RESP_SLVERR);
        expect_read(ADDR_COUNT, 0, {24'd0, model_count}, "count after refused write");
        end_test("clear and bus response");

        send_frame(8'h3A, 1'b0);
        send_frame(8'h5B, 1'b0);
        check_val("segments enabled", segs, expected_segs());
        write_ctrl(32'h0, 0);
        check_val("segments disabled", segs, expected_segs());
        expect_read(ADDR_CTRL, 0, {30'd0, model_en, 1'b0}, "ctrl readback");
        write_ctrl(32'h2, 0);
        end_test("display contents");

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests, failed_tests, checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: sources.f
verilog/ps2_kbd_pkg.sv
verilog/ps2_frame_rx.sv
verilog/key_event_filter.sv
verilog/scan_code_fifo.sv
verilog/seg_display.sv
verilog/kbd_ctrl_regs.sv
verilog/ps2_kbd_top.sv
bench/ps2_kbd_tb.sv

// File: verilog/kbd_ctrl_regs.sv
`timescale 1ns/1ps
module kbd_ctrl_regs (
    input  logic                    clk,
    input  logic                    rst_n,
    input  ps2_kbd_pkg::axil_req_t  req,
    output ps2_kbd_pkg::axil_rsp_t  rsp,
    input  logic [7:0]              head,
    input  ps2_kbd_pkg::fifo_stat_t stat,
    input  logic [7:0]              press_count,
    input  logic                    key_held,
    input  logic                    frame_err_seen,
    output logic                    pop,
    output logic                    clear,
    output logic                    display_en
);
    import ps2_kbd_pkg::*;

    logic        awready;
    logic        bvalid;
    logic [1:0]  bresp;
    logic        arready;
    logic        rvalid;
    logic [31:0] rdata;
    logic [31:0] rd_mux;
    logic        wr_ctrl;
    logic        rd_hs;

    assign wr_ctrl = ({req.awaddr[3:2], 2'b00} == ADDR_CTRL);
    assign rd_hs   = req.arvalid & arready;
    assign pop     = rd_hs && ({req.araddr[3:2], 2'b00} == ADDR_DATA) && !stat.empty;

    always_comb begin
        case ({req.araddr[3:2], 2'b00})
            ADDR_STATUS: rd_mux = {24'd0, fifo_count(stat), key_held, frame_err_seen,
                                   stat.overflow, ~stat.empty};
            ADDR_DATA:   rd_mux = stat.empty ? 32'd0 : {24'd0, head};
            ADDR_COUNT:  rd_mux = {24'd0, press_count};
            default:     rd_mux = {30'd0, display_en, 1'b0};
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // write channel
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            awready    <= 1'b0;
            bvalid     <= 1'b0;
            bresp      <= RESP_OKAY;
            clear      <= 1'b0;
            display_en <= 1'b1;
        end else begin
            clear   <= 1'b0;
            awready <= req.awvalid & req.wvalid & ~awready & ~bvalid;
            if (awready) begin                          // address and data accepted this cycle.
                bvalid <= 1'b1;
                if (wr_ctrl) begin
                    bresp <= RESP_OKAY;
                    if (req.wstrb[0]) begin
                        clear      <= req.wdata[0];
                        display_en <= req.wdata[1];
                    end
                end else begin
                    bresp <= RESP_SLVERR;               // the other registers are read only.
                end
            end else if (bvalid && req.bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // read channel
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (rd_hs) begin
            rdata <= rd_mux;                            // head is captured before the pop lands.
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            arready <= 1'b1;
            rvalid  <= 1'b0;
        end else if (rd_hs) begin
            arready <= 1'b0;
            rvalid  <= 1'b1;
        end else if (rvalid && req.rready) begin
            arready <= 1'b1;
            rvalid  <= 1'b0;
        end
    end

    always_comb begin
        rsp.awready = awready;
        rsp.wready  = awready;
        rsp.bresp   = bresp;
        rsp.bvalid  = bvalid;
        rsp.arready = arready;
        rsp.rdata   = rdata;
        rsp.rresp   = RESP_OKAY;
        rsp.rvalid  = rvalid;
    end

endmodule

// File: verilog/key_event_filter.sv
`timescale 1ns/1ps
module key_event_filter (
    input  logic                    clk,
    input  logic                    rst_n,
    input  ps2_kbd_pkg::ps2_frame_t frame,
    input  logic                    clear,
    output ps2_kbd_pkg::key_event_t key_event,
    output logic [7:0]              press_count,
    output logic                    key_held,
    output logic                    frame_err_seen
);
    import ps2_kbd_pkg::*;

    logic       good;
    logic       is_prefix;
    logic       is_repeat;
    logic       break_pending;
    logic [7:0] last_make;

    assign good      = frame.valid & ~frame.frame_err;
    assign is_prefix = (frame.data == BREAK_PREFIX);
    assign is_repeat = key_held && (frame.data == last_make);   // typematic repeat.

    assign key_event.valid = good & ~is_prefix & ~break_pending & ~is_repeat;
    assign key_event.code  = frame.data;

    always_ff @(posedge clk) begin
        if (key_event.valid) begin
            last_make <= frame.data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            break_pending  <= 1'b0;
            key_held       <= 1'b0;
            press_count    <= '0;
            frame_err_seen <= 1'b0;
        end else if (clear) begin
            break_pending  <= 1'b0;
            key_held       <= 1'b0;
            press_count    <= '0;
            frame_err_seen <= 1'b0;
        end else begin
            if (frame.valid && frame.frame_err) begin
                frame_err_seen <= 1'b1;
            end
            if (good) begin
                if (is_prefix) begin
                    break_pending <= 1'b1;
                end else if (break_pending) begin
                    break_pending <= 1'b0;              // the released key code itself.
                    key_held      <= 1'b0;
                end else if (!is_repeat) begin
                    key_held    <= 1'b1;
                    press_count <= press_count + 1'b1;
                end
            end
        end
    end

endmodule

// File: verilog/ps2_frame_rx.sv
`timescale 1ns/1ps
module ps2_frame_rx (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    ps2_clk,
    input  logic                    ps2_data,
    input  logic                    clear,
    output ps2_kbd_pkg::ps2_frame_t frame
);
    import ps2_kbd_pkg::*;

    logic [2:0]                      clk_sync;
    logic [1:0]                      data_sync;
    logic                            fall;
    logic [3:0]                      bit_cnt;
    logic [10:0]                     shreg;
    logic [10:0]                     shreg_nxt;
    logic [$clog2(IDLE_TIMEOUT)-1:0] idle_cnt;
    logic                            idle_expired;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            clk_sync  <= 3'b111;                        // ps2 lines idle high.
            data_sync <= 2'b11;
        end else begin
            clk_sync  <= {clk_sync[1:0], ps2_clk};
            data_sync <= {data_sync[0], ps2_data};
        end
    end

    assign fall      = clk_sync[2] & ~clk_sync[1];
    assign shreg_nxt = {data_sync[1], shreg[10:1]};     // lsb first, start bit ends in bit 0.

    always_ff @(posedge clk) begin
        if (fall) begin
            shreg <= shreg_nxt;
        end
    end

    assign idle_expired = (idle_cnt == $bits(idle_cnt)'(IDLE_TIMEOUT - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            idle_cnt <= '0;
        end else if (fall || clear) begin
            idle_cnt <= '0;
        end else if (!idle_expired) begin
            idle_cnt <= idle_cnt + 1'b1;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // bit count and frame check
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bit_cnt <= '0;
            frame   <= '0;
        end else begin
            frame.valid <= 1'b0;
            if (clear) begin
                bit_cnt <= '0;
            end else if (fall) begin
                if (bit_cnt == 4'd10) begin
                    bit_cnt         <= '0;
                    frame.valid     <= 1'b1;
                    frame.data      <= shreg_nxt[8:1];
                    frame.frame_err <= shreg_nxt[0] | ~shreg_nxt[10] | ~(^shreg_nxt[9:1]);
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end else if (idle_expired) begin
                bit_cnt <= '0;                          // a lost edge must not shift later frames.
            end
        end
    end

endmodule

// File: verilog/ps2_kbd_pkg.sv
package ps2_kbd_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // sizes and protocol constants
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int FIFO_DEPTH   = 8;
    localparam int FIFO_AW      = 3;
    localparam int IDLE_TIMEOUT = 4096;                 // clk cycles without a ps2 edge.

    localparam logic [7:0] BREAK_PREFIX = 8'hF0;
    localparam logic [6:0] SEG_BLANK    = 7'b1111111;   // all segments off.

    localparam logic [3:0] ADDR_STATUS = 4'h0;
    localparam logic [3:0] ADDR_DATA   = 4'h4;
    localparam logic [3:0] ADDR_COUNT  = 4'h8;
    localparam logic [3:0] ADDR_CTRL   = 4'hC;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // bundles between blocks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        logic       valid;
        logic [7:0] data;
        logic       frame_err;
    } ps2_frame_t;

    typedef struct packed {
        logic       valid;
        logic [7:0] code;
    } key_event_t;

    typedef struct packed {
        logic               empty;
        logic               full;
        logic               overflow;
        logic [FIFO_AW-1:0] level;      // wraps to 0 when full.
    } fifo_stat_t;

    typedef struct packed {
        logic [3:0]  awaddr;
        logic        awvalid;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        logic        wvalid;
        logic        bready;
        logic [3:0]  araddr;
        logic        arvalid;
        logic        rready;
    } axil_req_t;

    typedef struct packed {
        logic        awready;
        logic        wready;
        logic [1:0]  bresp;
        logic        bvalid;
        logic        arready;
        logic [31:0] rdata;
        logic [1:0]  rresp;
        logic        rvalid;
    } axil_rsp_t;

    typedef struct packed {
        logic [6:0] d5;
        logic [6:0] d4;
        logic [6:0] d3;
        logic [6:0] d2;
        logic [6:0] d1;
        logic [6:0] d0;
    } seg_bus_t;

    // number of stored entries, with the full case restored to 8.
    function automatic logic [3:0] fifo_count(fifo_stat_t s);
        return s.full ? 4'(FIFO_DEPTH) : {1'b0, s.level};
    endfunction

endpackage

// File: verilog/ps2_kbd_top.sv
`timescale 1ns/1ps
module ps2_kbd_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   ps2_clk,
    input  logic                   ps2_data,
    input  ps2_kbd_pkg::axil_req_t req,
    output ps2_kbd_pkg::axil_rsp_t rsp,
    output ps2_kbd_pkg::seg_bus_t  segs
);
    import ps2_kbd_pkg::*;

    ps2_frame_t frame;
    key_event_t key_event;
    fifo_stat_t stat;
    logic [7:0] head;
    logic [7:0] press_count;
    logic       key_held;
    logic       frame_err_seen;
    logic       pop;
    logic       clear;
    logic       display_en;

    ps2_frame_rx frame_rx_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .ps2_clk  (ps2_clk),
        .ps2_data (ps2_data),
        .clear    (clear),
        .frame    (frame)
    );

    key_event_filter filter_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .frame          (frame),
        .clear          (clear),
        .key_event      (key_event),
        .press_count    (press_count),
        .key_held       (key_held),
        .frame_err_seen (frame_err_seen)
    );

    scan_code_fifo fifo_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .key_event (key_event),
        .pop       (pop),
        .clear     (clear),
        .head      (head),
        .stat      (stat)
    );

    seg_display display_i (
        .head        (head),
        .stat        (stat),
        .press_count (press_count),
        .display_en  (display_en),
        .segs        (segs)
    );

    kbd_ctrl_regs regs_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .req            (req),
        .rsp            (rsp),
        .head           (head),
        .stat           (stat),
        .press_count    (press_count),
        .key_held       (key_held),
        .frame_err_seen (frame_err_seen),
        .pop            (pop),
        .clear          (clear),
        .display_en     (display_en)
    );

endmodule

// File: verilog/scan_code_fifo.sv
`timescale 1ns/1ps
module scan_code_fifo (
    input  logic                    clk,
    input  logic                    rst_n,
    input  ps2_kbd_pkg::key_event_t key_event,
    input  logic                    pop,
    input  logic                    clear,
    output logic [7:0]              head,
    output ps2_kbd_pkg::fifo_stat_t stat
);
    import ps2_kbd_pkg::*;

    logic [7:0]         mem [FIFO_DEPTH];
    logic [FIFO_AW:0]   wr_ptr;
    logic [FIFO_AW:0]   rd_ptr;
    logic [FIFO_AW:0]   fill;
    logic               empty;
    logic               full;
    logic               push;
    logic               pop_ok;
    logic               overflow;

    assign empty  = (wr_ptr == rd_ptr);
    assign full   = (wr_ptr[FIFO_AW] != rd_ptr[FIFO_AW]) &&
                    (wr_ptr[FIFO_AW-1:0] == rd_ptr[FIFO_AW-1:0]);
    assign fill   = wr_ptr - rd_ptr;
    assign push   = key_event.valid & ~full;
    assign pop_ok = pop & ~empty;

    assign head          = mem[rd_ptr[FIFO_AW-1:0]];
    assign stat.empty    = empty;
    assign stat.full     = full;
    assign stat.overflow = overflow;
    assign stat.level    = fill[FIFO_AW-1:0];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr[FIFO_AW-1:0]] <= key_event.code;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            overflow <= 1'b0;
        end else if (clear) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            overflow <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_ok) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (key_event.valid && full) begin
                overflow <= 1'b1;                       // the code is lost because the keyboard cannot stall.
            end
        end
    end

endmodule

// File: verilog/seg_display.sv
`timescale 1ns/1ps
module seg_display (
    input  logic [7:0]              head,
    input  ps2_kbd_pkg::fifo_stat_t stat,
    input  logic [7:0]              press_count,
    input  logic                    display_en,
    output ps2_kbd_pkg::seg_bus_t   segs
);
    import ps2_kbd_pkg::*;

    logic [6:0] pc_mod;
    logic [3:0] pc_tens;
    logic [3:0] pc_units;
    logic [3:0] lvl;
    logic [3:0] lvl_tens;
    logic [3:0] lvl_units;

    // segment order is abcdefg, a low bit lights the segment.
    function automatic logic [6:0] seg_encode(logic [3:0] num);
        case (num)
            4'h0: return 7'b0000001;
            4'h1: return 7'b1001111;
            4'h2: return 7'b0010010;
            4'h3: return 7'b0000110;
            4'h4: return 7'b1001100;
            4'h5: return 7'b0100100;
            4'h6: return 7'b0100000;
            4'h7: return 7'b0001111;
            4'h8: return 7'b0000000;
            4'h9: return 7'b0000100;
            4'hA: return 7'b0001000;
            4'hB: return 7'b1100000;                    // lower case b.
            4'hC: return 7'b0110001;
            4'hD: return 7'b1000010;                    // lower case d.
            4'hE: return 7'b0110000;
            default: return 7'b0111000;
        endcase
    endfunction

    assign pc_mod    = 7'(press_count % 8'd100);
    assign pc_tens   = 4'(pc_mod / 7'd10);
    assign pc_units  = 4'(pc_mod % 7'd10);
    assign lvl       = fifo_count(stat);
    assign lvl_tens  = lvl / 4'd10;
    assign lvl_units = lvl % 4'd10;

    always_comb begin
        segs = {6{SEG_BLANK}};
        if (display_en) begin
            if (!stat.empty) begin
                segs.d0 = seg_encode(head[3:0]);
                segs.d1 = seg_encode(head[7:4]);
            end
            segs.d2 = seg_encode(pc_units);
            segs.d3 = seg_encode(pc_tens);
            segs.d4 = seg_encode(lvl_units);
            segs.d5 = seg_encode(lvl_tens);
        end
    end

endmodule
